//--- hitReport.sv
// lane result combiner and hit flag
`timescale 1ns/10ps

module hitReport
	import rhythmPkg::*;
(
	input logic clock,
	input logic resetn,
	input logic resetScore,
	input laneResult laneResults [LANE_COUNT],
	output logic isNote,
	output logic [PITCH_BITS-1:0] note,
	output logic pressedNote
);

	logic [LANE_COUNT-1:0] noteLanes;
	logic [LANE_COUNT-1:0] hitLanes;
	logic singleNote;

	always_comb
	begin
		for (int i = 0; i < LANE_COUNT; i++)
		begin
			noteLanes[i] = laneResults[i].isNote;
			hitLanes[i] = laneResults[i].hit;
		end
	end

	assign isNote = |noteLanes;

	// exactly one lane with a note
	assign singleNote = isNote && ((noteLanes & (noteLanes - 1'b1)) == '0);

	always_comb
	begin
		note = '0;
		if (singleNote == 1'b1)
		begin
			for (int i = 0; i < LANE_COUNT; i++)
			begin
				if (noteLanes[i] == 1'b1)
					note = laneResults[i].pitch;
			end
		end
	end

	// sticky until the score is reset
	always_ff @(posedge clock)
	begin
		if (resetn == 1'b0)
			pressedNote <= 1'b0;
		else if (resetScore == 1'b1)
			pressedNote <= 1'b0;
		else if (hitLanes != '0)
			pressedNote <= 1'b1;
	end

endmodule

//--- list.f
rhythmPkg.sv
noteSequencer.sv
noteLane.sv
hitReport.sv
rhythmCore.sv
tbClock.sv
rhythmCore_props.sv
rhythmCore_tb.sv

//--- noteLane.sv
// scrolling note lane with hit judging
`timescale 1ns/10ps

module noteLane
	import rhythmPkg::*;
(
	input logic clock,
	input logic resetn,
	input logic shift,
	input logic inject,
	input logic pressPhase,
	input logic press,
	input laneCell headCell,
	output laneResult result
);

	laneCell [LANE_DEPTH-1:0] rows; // row 0 is the top of the lane
	laneCell entryCell;
	laneCell judged;
	logic judgedHit;

	// only the selected lane takes the head cell
	assign entryCell = (inject == 1'b1) ? headCell : '0;

	assign judged = rows[HIT_ROW];
	assign judgedHit = judged.colour != '0; // non-black box at the line

	always_ff @(posedge clock)
	begin
		if (resetn == 1'b0)
		begin
			rows <= '0;
			result <= '0;
		end
		else if (shift == 1'b1)
		begin
			// scroll down one row
			rows <= {rows[LANE_DEPTH-2:0], entryCell};
		end
		else if (pressPhase == 1'b1)
		begin
			if (press == 1'b1)
			begin
				result.isNote <= judged.present;
				result.pitch <= judged.pitch;
				result.hit <= judgedHit;
				if (judgedHit == 1'b1)
				begin
					// black out the note around the line
					for (int r = HIT_ROW - HIT_WINDOW; r <= HIT_ROW + HIT_WINDOW; r++)
					begin
						if (rows[r].present == 1'b1)
							rows[r].colour <= '0;
					end
				end
			end
			else
			begin
				result.isNote <= 1'b0;
				result.hit <= 1'b0;
			end
		end
	end

endmodule

//--- noteSequencer.sv
// song note sequencer
`timescale 1ns/10ps

module noteSequencer
	import rhythmPkg::*;
(
	input logic clock,
	input logic resetn,
	input logic shift,
	output laneCell headCell,
	output logic [LANE_COUNT-1:0] injectLanes,
	output logic songDone
);

	logic [$bits(noteWord)-1:0] songTable [SONG_WORDS];

	logic [ADDR_WIDTH-1:0] address;
	noteWord currentNote;
	noteWord nextNote;
	logic [WAIT_BITS-1:0] emitted; // cells put out for this note
	logic [WAIT_BITS-1:0] elapsed; // shifts since the note was loaded
	logic notePresent;
	logic atWait;
	logic lastWord;

	initial
	begin
		$readmemh("song.hex", songTable);
	end

	assign nextNote = noteWord'(songTable[address]);

	// hand over on the shift where elapsed reaches the wait
	assign atWait = elapsed == currentNote.waitTime;
	assign lastWord = currentNote.waitTime == WAIT_BITS'(END_WAIT);

	assign notePresent = emitted < WAIT_BITS'(currentNote.length);

	always_ff @(posedge clock)
	begin
		if (resetn == 1'b0)
		begin
			address <= '0;
			currentNote <= '0; // zero wait, so the first shift loads word 0
			emitted <= '0;
			elapsed <= '0;
			songDone <= 1'b0;
		end
		else if (shift == 1'b1 && songDone == 1'b0)
		begin
			if (atWait == 1'b1 && lastWord == 1'b0)
			begin
				currentNote <= nextNote;
				address <= address + 1'b1;
				emitted <= '0;
				elapsed <= '0;
			end
			else
			begin
				emitted <= emitted + 1'b1;
				elapsed <= elapsed + 1'b1;
				if (atWait == 1'b1)
					songDone <= 1'b1; // counters freeze from here on
			end
		end
	end

	// head cell and lane decode for the current note
	always_comb
	begin
		headCell = '0;
		injectLanes = '0;
		if (notePresent == 1'b1)
		begin
			headCell.present = 1'b1;
			headCell.colour = currentNote.colour;
			headCell.pitch = currentNote.pitch;
			injectLanes[currentNote.lane] = 1'b1;
		end
	end

endmodule

//--- rhythmCore.sv
// four lane note datapath
`timescale 1ns/10ps

module rhythmCore
	import rhythmPkg::*;
(
	input logic clock,
	input logic resetn,
	input logic shift,
	input logic pressPhase,
	input logic [LANE_COUNT-1:0] pressKeys,
	input logic resetScore,
	output logic songDone,
	output logic isNote,
	output logic [PITCH_BITS-1:0] note,
	output logic pressedNote
);

	laneCell headCell;
	logic [LANE_COUNT-1:0] injectLanes;
	laneResult laneResults [LANE_COUNT];

	noteSequencer seq0 (
		.clock(clock),
		.resetn(resetn),
		.shift(shift),
		.headCell(headCell),
		.injectLanes(injectLanes),
		.songDone(songDone)
	);

	// one lane per key
	generate
		for (genvar i = 0; i < LANE_COUNT; i++)
		begin : lanes
			noteLane lane (
				.clock(clock),
				.resetn(resetn),
				.shift(shift),
				.inject(injectLanes[i]),
				.pressPhase(pressPhase),
				.press(pressKeys[i]),
				.headCell(headCell),
				.result(laneResults[i])
			);
		end
	endgenerate

	hitReport report0 (
		.clock(clock),
		.resetn(resetn),
		.resetScore(resetScore),
		.laneResults(laneResults),
		.isNote(isNote),
		.note(note),
		.pressedNote(pressedNote)
	);

endmodule

//--- rhythmCore_props.sv
// sequencer and hit flag checks
`timescale 1ns/10ps

module rhythmCore_props
	import rhythmPkg::*;
(
	input logic clock,
	input logic resetn,
	input logic [LANE_COUNT-1:0] injectLanes,
	input logic songDone,
	input logic resetScore,
	input logic pressedNote
);

	// head cell goes to one lane at most
	injectOneHot: assert property (@(posedge clock) disable iff (resetn == 1'b0)
		$onehot0(injectLanes))
		else $error("more than one lane selected for injection: %b", injectLanes);

	songDoneHeld: assert property (@(posedge clock)
		$fell(songDone) |-> $past(resetn) == 1'b0)
		else $error("songDone fell while out of reset");

	// sticky flag, only resetScore or reset clears it
	pressedNoteHeld: assert property (@(posedge clock)
		$fell(pressedNote) |-> ($past(resetScore) == 1'b1 || $past(resetn) == 1'b0))
		else $error("pressedNote fell without resetScore");

endmodule

bind rhythmCore rhythmCore_props props0 (
	.clock(clock),
	.resetn(resetn),
	.injectLanes(injectLanes),
	.songDone(songDone),
	.resetScore(resetScore),
	.pressedNote(pressedNote)
);

//--- rhythmCore_tb.sv
// rhythm core testbench
`timescale 1ns/10ps

module rhythmCore_tb
	import rhythmPkg::*;
();

	typedef struct packed {
		logic [7:0] shiftCount;
		logic [LANE_COUNT-1:0] keys;
		logic resetScore;
	} stimulusRow;

	typedef struct packed {
		logic isNote;
		logic [PITCH_BITS-1:0] note;
		logic pressedNote;
		logic songDone;
	} outputRow;

	logic clock;
	logic resetn;
	logic shift;
	logic pressPhase;
	logic [LANE_COUNT-1:0] pressKeys;
	logic resetScore;
	logic songDone;
	logic isNote;
	logic [PITCH_BITS-1:0] note;
	logic pressedNote;

	string testNames [$];
	stimulusRow stimTable [$];
	outputRow expectTable [$];

	int passCount = 0;
	int failCount = 0;
	int cycleCount = 0;
	int cycleLimit = 1000;
	bit verdictShown = 1'b0;

	tbClock clock0 (
		.clock(clock),
		.resetn(resetn)
	);

	rhythmCore dut0 (
		.clock(clock),
		.resetn(resetn),
		.shift(shift),
		.pressPhase(pressPhase),
		.pressKeys(pressKeys),
		.resetScore(resetScore),
		.songDone(songDone),
		.isNote(isNote),
		.note(note),
		.pressedNote(pressedNote)
	);

	task automatic addTest(input string name, input int shifts,
		input logic [LANE_COUNT-1:0] keys, input logic clearScore, input logic expIsNote,
		input logic [PITCH_BITS-1:0] expNote, input logic expPressed, input logic expDone);
		stimulusRow stim;
		outputRow expected;
		stim.shiftCount = 8'(shifts);
		stim.keys = keys;
		stim.resetScore = clearScore;
		expected.isNote = expIsNote;
		expected.note = expNote;
		expected.pressedNote = expPressed;
		expected.songDone = expDone;
		testNames.push_back(name);
		stimTable.push_back(stim);
		expectTable.push_back(expected);
	endtask

	// shift counts add up along the song
	task automatic buildTable();
		// word 0 enters lane 1 on shifts 2 and 3
		addTest("firstHit", 102, 4'b0010, 1'b0, 1'b1, 4'd5, 1'b1, 1'b0);
		addTest("secondPress", 1, 4'b0010, 1'b0, 1'b1, 4'd5, 1'b1, 1'b0); // blacked out
		addTest("scoreReset", 0, 4'b0000, 1'b1, 1'b0, 4'd0, 1'b0, 1'b0);
		addTest("pressAfterReset", 0, 4'b0010, 1'b0, 1'b1, 4'd5, 1'b0, 1'b0);
		addTest("emptyLane", 0, 4'b1000, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0);
		addTest("laneZeroHit", 10, 4'b0001, 1'b0, 1'b1, 4'd9, 1'b1, 1'b0); // shift 13 cell
		// score cleared with the press so the flag shows this hit
		addTest("laneTwoHit", 4, 4'b0100, 1'b1, 1'b1, 4'd3, 1'b1, 1'b0);
		// lane 3 note at the line and lane 1 empty
		addTest("twoKeys", 6, 4'b1010, 1'b1, 1'b1, 4'd12, 1'b1, 1'b0);
		addTest("latePress", 10, 4'b0010, 1'b1, 1'b0, 4'd0, 1'b0, 1'b0); // cells past row 100
		// end word loaded on shift 41 and done on shift 161
		addTest("beforeEnd", 27, 4'b0000, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0);
		addTest("songEnd", 1, 4'b0000, 1'b0, 1'b0, 4'd0, 1'b0, 1'b1);
		addTest("afterEnd", 20, 4'b0000, 1'b1, 1'b0, 4'd0, 1'b0, 1'b1);
	endtask

	task automatic driveCycle(input logic doShift, input logic doPress,
		input logic [LANE_COUNT-1:0] keys, input logic clearScore);
		@(posedge clock);
		shift <= doShift;
		pressPhase <= doPress;
		pressKeys <= keys;
		resetScore <= clearScore;
	endtask

	task automatic runTest(input int index);
		stimulusRow stim;
		outputRow expected;
		int step;
		int mismatches;
		stim = stimTable[index];
		expected = expectTable[index];
		mismatches = 0;
		for (step = 0; step < int'(stim.shiftCount); step++)
			driveCycle(1'b1, 1'b0, '0, 1'b0);
		driveCycle(1'b0, 1'b1, stim.keys, stim.resetScore);
		driveCycle(1'b0, 1'b0, '0, 1'b0);
		@(posedge clock); // lane result then hit flag
		@(negedge clock);
		if (isNote !== expected.isNote)
		begin
			$display("ERROR %s isNote expected %0d actual %0d",
				testNames[index], expected.isNote, isNote);
			mismatches++;
		end
		if (note !== expected.note)
		begin
			$display("ERROR %s note expected %0d actual %0d",
				testNames[index], expected.note, note);
			mismatches++;
		end
		if (pressedNote !== expected.pressedNote)
		begin
			$display("ERROR %s pressedNote expected %0d actual %0d",
				testNames[index], expected.pressedNote, pressedNote);
			mismatches++;
		end
		if (songDone !== expected.songDone)
		begin
			$display("ERROR %s songDone expected %0d actual %0d",
				testNames[index], expected.songDone, songDone);
			mismatches++;
		end
		if (mismatches == 0)
		begin
			passCount++;
			$display("test %s ok", testNames[index]);
		end
		else
		begin
			failCount++;
			$display("test %s had %0d mismatches", testNames[index], mismatches);
		end
	endtask

	initial
	begin
		shift = 1'b0;
		pressPhase = 1'b0;
		pressKeys = '0;
		resetScore = 1'b0;
		buildTable();
		cycleLimit = 200;
		foreach (stimTable[i])
			cycleLimit += int'(stimTable[i].shiftCount) + 4;
		wait (resetn == 1'b1);
		foreach (stimTable[i])
			runTest(i);
		$display("tests %0d, ok %0d, failing %0d", stimTable.size(), passCount, failCount);
		verdictShown = 1'b1;
		if (failCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// run length guard
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("timeout, the test table did not finish within %0d cycles", cycleLimit);
			verdictShown = 1'b1;
			$display("Verification failed");
			$finish;
		end
	end

	// stopped early by a failing assertion
	final
	begin
		if (verdictShown == 1'b0)
		begin
			$display("simulation stopped before all tests finished");
			$display("Verification failed");
		end
	end

endmodule

//--- rhythmPkg.sv
// rhythm game note datapath definitions
package rhythmPkg;

	// playfield geometry
	localparam int LANE_COUNT = 4;
	localparam int LANE_BITS = $clog2(LANE_COUNT);
	localparam int LANE_DEPTH = 116;
	localparam int HIT_ROW = 100; // judged row, the white line
	localparam int HIT_WINDOW = 3; // rows cleared above and below on a hit

	// song table
	localparam int SONG_WORDS = 256;
	localparam int ADDR_WIDTH = $clog2(SONG_WORDS);
	localparam int END_WAIT = 119; // wait value of the closing word

	// field widths
	localparam int COLOUR_BITS = 3;
	localparam int PITCH_BITS = 4;
	localparam int LENGTH_BITS = 4;
	localparam int WAIT_BITS = 7;

	// one song table entry, lane in the top bits
	typedef struct packed {
		logic [LANE_BITS-1:0] lane;
		logic [COLOUR_BITS-1:0] colour;
		logic [PITCH_BITS-1:0] pitch;
		logic [LENGTH_BITS-1:0] length; // cells to inject
		logic [WAIT_BITS-1:0] waitTime; // shifts until next word
	} noteWord;

	// content of one lane row
	typedef struct packed {
		logic present;
		logic [COLOUR_BITS-1:0] colour; // black once hit
		logic [PITCH_BITS-1:0] pitch;
	} laneCell;

	// lane verdict after a press phase
	typedef struct packed {
		logic isNote;
		logic [PITCH_BITS-1:0] pitch;
		logic hit;
	} laneResult;

endpackage

//--- run.sh
#!/bin/sh
# compile and run the rhythm core testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module rhythmCore_tb \
	-Mdir obj_dir > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/VrhythmCore_tb > sim.log 2>&1
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1

//--- song.hex
// note words of the test song, five hex digits per word
// columns: lane[19:18] colour[17:15] pitch[14:11] length[10:7] wait[6:0]
5290A // lane 1, pitch 5, two cells, wait 10
24883 // lane 0, pitch 9, one cell, wait 3
89905 // lane 2, pitch 3, two cells, wait 5
F6184 // lane 3, pitch 12, three cells, wait 4
38882 // lane 0, pitch 1, one cell, wait 2
5B906 // lane 1, pitch 7, two cells, wait 6
AF083 // lane 2, pitch 14, one cell, wait 3
00077 // end of song, wait 119

//--- tbClock.sv
// testbench clock and reset
`timescale 1ns/10ps

module tbClock
(
	output logic clock,
	output logic resetn
);

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock; // 8 ns period
	end

	initial
	begin
		resetn = 1'b0;
		repeat (2) @(posedge clock);
		resetn <= 1'b1; // low for two rising edges
	end

endmodule
